/* rtl/band_macros.svh */
// ###################################################################
// width and lane count of the band splitter datapath
// include before any package or module that sizes samples or words
// ###################################################################

`ifndef BAND_MACROS_SVH
`define BAND_MACROS_SVH

// bits per signed sample
`define BAND_SAMPLE_WIDTH 16

// samples carried side by side in one stream word, at least two
`define BAND_PARALLEL_SAMPLES 2

`endif

/* rtl/sample_pkg.sv */
// ###################################################################
// sample and word types shared by every datapath block
// import with a wildcard in the module header
// ###################################################################

`include "band_macros.svh"

package sample_pkg;

  // one signed sample as it sits in a lane
  typedef logic signed [`BAND_SAMPLE_WIDTH-1:0] sample_t;

  // one stream word, lane 0 holds the oldest sample and the last lane the newest
  // so the predecessor of lane i is lane i-1 of the same word
  typedef sample_t [`BAND_PARALLEL_SAMPLES-1:0] word_t;

endpackage

/* rtl/band_ctrl_pkg.sv */
// ###################################################################
// control encodings of the band splitter
// holds the output mode opcodes and the fork state machine encoding
// ###################################################################

`include "band_macros.svh"

package band_ctrl_pkg;

  // output selection per lane, only changed while the pipeline is empty
  typedef enum logic [1:0] {
    mode_high = 2'd0,
    mode_low  = 2'd1,
    mode_sum  = 2'd2
  } band_mode_t;

  // which branch has already taken the word that is on the input
  typedef enum logic [1:0] {
    fork_both_pending = 2'd0,
    fork_high_taken   = 2'd1,
    fork_low_taken    = 2'd2
  } fork_state_t;

endpackage

/* rtl/axis_stream_fork.sv */
// ###################################################################
// broadcasts one valid/ready input stream to a high and a low branch
// each word goes to each branch exactly once, data passes through
// ###################################################################

`timescale 1ns/100ps
`include "band_macros.svh"

module axis_stream_fork import sample_pkg::*, band_ctrl_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  word_t in_data,
  input  logic  in_valid,
  output logic  in_ready,
  output word_t hi_in_data,
  output logic  hi_in_valid,
  input  logic  hi_in_ready,
  output word_t lo_in_data,
  output logic  lo_in_valid,
  input  logic  lo_in_ready
);

  fork_state_t state;

  // both branches see the same word, only the valid is gated
  assign hi_in_data = in_data;
  assign lo_in_data = in_data;

  // a branch that already took the word must not see it again
  assign hi_in_valid = in_valid && (state != fork_high_taken);
  assign lo_in_valid = in_valid && (state != fork_low_taken);

  // the input completes once every branch still owed the word is ready
  assign in_ready = ((state == fork_high_taken) || hi_in_ready) &&
                    ((state == fork_low_taken) || lo_in_ready);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= fork_both_pending;
    end else if (in_valid && in_ready) begin
      // word is fully delivered, the next one starts fresh
      state <= fork_both_pending;
    end else if (in_valid && (state == fork_both_pending)) begin
      // only one branch could take it this cycle, remember which one
      if (hi_in_ready) begin
        state <= fork_high_taken;
      end else if (lo_in_ready) begin
        state <= fork_low_taken;
      end
    end
  end

endmodule

/* rtl/axis_differentiator.sv */
// ###################################################################
// high band branch, halved first difference of the sample stream
// one word in, one registered word out, one cycle of latency
// ###################################################################

`timescale 1ns/100ps
`include "band_macros.svh"

module axis_differentiator import sample_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  word_t in_data,
  input  logic  in_valid,
  output logic  in_ready,
  output word_t out_data,
  output logic  out_valid,
  input  logic  out_ready
);

  localparam int W = `BAND_SAMPLE_WIDTH;
  localparam int N = `BAND_PARALLEL_SAMPLES;

  // newest sample of the previous accepted word, feeds lane 0
  sample_t prev_sample;
  // each lane's predecessor, lined up with the lane itself
  word_t   pred_word;
  word_t   next_data;
  logic    accept;

  // the register can take a word when it is empty or drains this cycle
  assign in_ready = !out_valid || out_ready;
  assign accept   = in_valid && in_ready;

  // shift the word up by one lane and put the held sample into lane 0
  assign pred_word = word_t'({in_data[N-2:0], prev_sample});

  always_comb begin
    logic [W:0] cur_ext;
    logic [W:0] pred_ext;
    logic [W:0] diff_ext;
    for (int i = 0; i < N; i++) begin
      // one extra bit so the difference cannot wrap
      cur_ext  = {in_data[i][W-1], in_data[i]};
      pred_ext = {pred_word[i][W-1], pred_word[i]};
      diff_ext = cur_ext - pred_ext;
      // dropping the lsb is an arithmetic shift, which floors toward minus infinity
      next_data[i] = sample_t'(diff_ext[W:1]);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid   <= 1'b0;
      prev_sample <= '0;
    end else if (accept) begin
      out_valid   <= 1'b1;
      prev_sample <= in_data[N-1];
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  // payload only moves on an accepted word
  always_ff @(posedge clk) begin
    if (accept) begin
      out_data <= next_data;
    end
  end

endmodule

/* rtl/axis_pair_averager.sv */
// ###################################################################
// low band branch, halved sum of each sample and its predecessor
// same handshake and latency as the differentiator branch
// ###################################################################

`timescale 1ns/100ps
`include "band_macros.svh"

module axis_pair_averager import sample_pkg::*; (
  input  logic  clk,
  input  logic  reset,
  input  word_t in_data,
  input  logic  in_valid,
  output logic  in_ready,
  output word_t out_data,
  output logic  out_valid,
  input  logic  out_ready
);

  localparam int W = `BAND_SAMPLE_WIDTH;
  localparam int N = `BAND_PARALLEL_SAMPLES;

  // last lane of the previous word, zero until the first word arrives
  sample_t prev_sample;
  word_t   pred_word;
  word_t   next_data;
  logic    accept;

  assign in_ready = !out_valid || out_ready;
  assign accept   = in_valid && in_ready;

  // lane i is paired with lane i-1, lane 0 with the held sample
  assign pred_word = word_t'({in_data[N-2:0], prev_sample});

  always_comb begin
    logic [W:0] cur_ext;
    logic [W:0] pred_ext;
    logic [W:0] sum_ext;
    for (int i = 0; i < N; i++) begin
      cur_ext  = {in_data[i][W-1], in_data[i]};
      pred_ext = {pred_word[i][W-1], pred_word[i]};
      sum_ext  = cur_ext + pred_ext;
      // half of a sum of two samples always lands back in sample range
      next_data[i] = sample_t'(sum_ext[W:1]);
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid   <= 1'b0;
      prev_sample <= '0;
    end else if (accept) begin
      out_valid   <= 1'b1;
      prev_sample <= in_data[N-1];
    end else if (out_ready) begin
      // drained with nothing new behind it
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      out_data <= next_data;
    end
  end

endmodule

/* rtl/axis_band_combiner.sv */
// ###################################################################
// joins the high and low band streams into one output stream
// per lane it passes one band or the saturated sum, chosen by mode
// ###################################################################

`timescale 1ns/100ps
`include "band_macros.svh"

module axis_band_combiner import sample_pkg::*, band_ctrl_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  band_mode_t mode,
  input  word_t      hi_data,
  input  logic       hi_valid,
  output logic       hi_ready,
  input  word_t      lo_data,
  input  logic       lo_valid,
  output logic       lo_ready,
  output word_t      out_data,
  output logic       out_valid,
  input  logic       out_ready
);

  localparam int W = `BAND_SAMPLE_WIDTH;
  localparam int N = `BAND_PARALLEL_SAMPLES;

  // largest and smallest values a lane can hold
  localparam sample_t SAMPLE_MAX = {1'b0, {(W-1){1'b1}}};
  localparam sample_t SAMPLE_MIN = {1'b1, {(W-1){1'b0}}};

  logic  space;
  logic  accept;
  word_t next_data;

  // output register is free when empty or being drained right now
  assign space = !out_valid || out_ready;

  // the two bands are taken as a pair, never one without the other
  assign accept   = hi_valid && lo_valid && space;
  assign hi_ready = accept;
  assign lo_ready = accept;

  always_comb begin
    logic [W:0] sum_ext;
    sample_t    sum_sat;
    for (int i = 0; i < N; i++) begin
      sum_ext = {hi_data[i][W-1], hi_data[i]} + {lo_data[i][W-1], lo_data[i]};
      // the top two bits disagree only when the sum left the sample range
      if (sum_ext[W] != sum_ext[W-1]) begin
        sum_sat = sum_ext[W] ? SAMPLE_MIN : SAMPLE_MAX;
      end else begin
        sum_sat = sample_t'(sum_ext[W-1:0]);
      end
      case (mode)
        mode_high: next_data[i] = hi_data[i];
        mode_low:  next_data[i] = lo_data[i];
        mode_sum:  next_data[i] = sum_sat;
        // unused code falls back to the rebuilt signal
        default:   next_data[i] = sum_sat;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (accept) begin
      out_valid <= 1'b1;
    end else if (out_ready) begin
      out_valid <= 1'b0;
    end
  end

  // result register, loaded only when a band pair is consumed
  always_ff @(posedge clk) begin
    if (accept) begin
      out_data <= next_data;
    end
  end

endmodule

/* rtl/axis_band_split_top.sv */
// ###################################################################
// two band splitter, fork into high and low branches, then recombine
// mode must only change while no word is in flight
// ###################################################################

`timescale 1ns/100ps
`include "band_macros.svh"

module axis_band_split_top import sample_pkg::*, band_ctrl_pkg::*; (
  input  logic       clk,
  input  logic       reset,
  input  band_mode_t mode,
  input  word_t      in_data,
  input  logic       in_valid,
  output logic       in_ready,
  output word_t      out_data,
  output logic       out_valid,
  input  logic       out_ready
);

  // fork to branches
  word_t hi_in_data;
  logic  hi_in_valid;
  logic  hi_in_ready;
  word_t lo_in_data;
  logic  lo_in_valid;
  logic  lo_in_ready;

  // branches to combiner
  word_t hi_data;
  logic  hi_valid;
  logic  hi_ready;
  word_t lo_data;
  logic  lo_valid;
  logic  lo_ready;

  axis_stream_fork fork_i (
    .clk, .reset, .in_data, .in_valid, .in_ready,
    .hi_in_data, .hi_in_valid, .hi_in_ready,
    .lo_in_data, .lo_in_valid, .lo_in_ready
  );

  axis_differentiator diff_i (
    .clk, .reset,
    .in_data(hi_in_data), .in_valid(hi_in_valid), .in_ready(hi_in_ready),
    .out_data(hi_data), .out_valid(hi_valid), .out_ready(hi_ready)
  );

  axis_pair_averager avg_i (
    .clk, .reset,
    .in_data(lo_in_data), .in_valid(lo_in_valid), .in_ready(lo_in_ready),
    .out_data(lo_data), .out_valid(lo_valid), .out_ready(lo_ready)
  );

  axis_band_combiner comb_i (
    .clk, .reset, .mode,
    .hi_data, .hi_valid, .hi_ready,
    .lo_data, .lo_valid, .lo_ready,
    .out_data, .out_valid, .out_ready
  );

endmodule

/* verification/band_split_ref.svh */
// ###################################################################
// reference model of the band splitter and the stimulus LFSR
// included inside the testbench module after the package imports
// ###################################################################

`ifndef BAND_SPLIT_REF_SVH
`define BAND_SPLIT_REF_SVH

// range of one sample as plain integers
localparam int sample_max = (1 << (`BAND_SAMPLE_WIDTH - 1)) - 1;
localparam int sample_min = -(1 << (`BAND_SAMPLE_WIDTH - 1));

// galois form of x^16 + x^14 + x^13 + x^11 + 1, one step per random bit
function automatic logic [15:0] lfsr_step(input logic [15:0] state);
  if (state[0]) begin
    return (state >> 1) ^ 16'hb400;
  end
  return state >> 1;
endfunction

// a sample argument is signed, so the widening keeps the sign
function automatic int lane_value(input sample_t s);
  return int'(s);
endfunction

// a signed shift by one rounds toward minus infinity
function automatic int floor_half(input int v);
  return v >>> 1;
endfunction

function automatic int clamp_sample(input int v);
  if (v > sample_max) begin
    return sample_max;
  end
  if (v < sample_min) begin
    return sample_min;
  end
  return v;
endfunction

// expected output for one input word, given the newest sample of the word before it
function automatic word_t ref_word(input word_t w, input sample_t prev, input band_mode_t m);
  word_t res;
  int    cur;
  int    pred;
  int    high;
  int    low;
  pred = lane_value(prev);
  for (int i = 0; i < `BAND_PARALLEL_SAMPLES; i++) begin
    cur  = lane_value(w[i]);
    high = floor_half(cur - pred);
    low  = floor_half(cur + pred);
    case (m)
      mode_high: res[i] = sample_t'(high);
      mode_low:  res[i] = sample_t'(low);
      default:   res[i] = sample_t'(clamp_sample(high + low));
    endcase
    // this lane is the predecessor of the next one
    pred = cur;
  end
  return res;
endfunction

`endif

/* verification/band_split_tb.sv */
// ###################################################################
// testbench of the two band splitter, drives words through all modes
// checks every output against the reference model, then the word count
// ###################################################################

`timescale 1ns/100ps
`include "band_macros.svh"

module band_split_tb
  import sample_pkg::*, band_ctrl_pkg::*;
();

  localparam int sample_w      = `BAND_SAMPLE_WIDTH;
  localparam int lanes         = `BAND_PARALLEL_SAMPLES;
  localparam int reset_cycles  = 4;
  localparam int high_words    = 40;
  localparam int low_words     = 60;
  localparam int sum_words     = 50;
  localparam int extreme_words = 16;
  localparam int drain_cycles  = 8;
  // random valid and ready cost about four cycles per word
  localparam int planned_cycles = reset_cycles + high_words + 4 * low_words + sum_words +
                                  2 * extreme_words + 5 * (drain_cycles + 3);
  localparam int timeout_limit  = 2 * planned_cycles + 100;

  logic       clk;
  logic       reset;
  band_mode_t mode;
  word_t      in_data;
  logic       in_valid;
  logic       in_ready;
  word_t      out_data;
  logic       out_valid;
  logic       out_ready;

  logic [15:0] lfsr_state;
  sample_t     ref_prev;
  word_t       exp_q[$];
  word_t       in_q[$];
  int          acc_q[$];
  int          cycle;
  int          sent_count;
  int          recv_count;
  int          pass_count;
  int          fail_count;
  bit          check_latency;

  `include "band_split_ref.svh"

  axis_band_split_top dut_i (
    .clk, .reset, .mode,
    .in_data, .in_valid, .in_ready,
    .out_data, .out_valid, .out_ready
  );

  always #50 clk = ~clk;

  // collects n bits from the LFSR, newest bit in the lsb
  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // extreme words alternate full scale positive and negative sample by sample
  function automatic word_t make_word(input int index, input bit extremes);
    word_t       w;
    logic [31:0] r;
    for (int i = 0; i < lanes; i++) begin
      if (extremes) begin
        w[i] = ((index * lanes + i) % 2 == 0) ? sample_t'(sample_max) : sample_t'(sample_min);
      end else begin
        r = random_bits(sample_w);
        w[i] = sample_t'(r[sample_w-1:0]);
      end
    end
    return w;
  endfunction

  // sends count words, valid is held with stable data until the transfer
  task automatic stream_words(input int count, input bit random_valid,
                              input bit random_ready, input bit extremes);
    int          made;
    int          taken;
    bit          moved;
    bit          raise;
    logic [31:0] r;
    made  = 0;
    taken = 0;
    moved = 1'b0;
    while (taken < count) begin
      @(negedge clk);
      if (moved) begin
        in_valid = 1'b0;
      end
      if (!in_valid && made < count) begin
        raise = 1'b1;
        if (random_valid) begin
          r = random_bits(1);
          raise = r[0];
        end
        if (raise) begin
          in_data  = make_word(made, extremes);
          in_valid = 1'b1;
          made++;
        end
      end
      if (random_ready) begin
        r = random_bits(1);
        out_ready = r[0];
      end else begin
        out_ready = 1'b1;
      end
      @(posedge clk);
      moved = in_valid && in_ready;
      if (moved) begin
        taken++;
      end
    end
  endtask

  // stop sending and let every accepted word leave before the mode may change
  // a word still owed after drain_cycles is left for the word count check
  task automatic drain_pipeline();
    int waited;
    waited = 0;
    @(negedge clk);
    in_valid  = 1'b0;
    out_ready = 1'b1;
    while (exp_q.size() != 0 && waited < drain_cycles) begin
      @(negedge clk);
      waited++;
    end
    repeat (2) @(negedge clk);
  endtask

  task automatic report_test(input string name, input int words_before, input int fails_before);
    $display("%s finished, %0d words received, %0d failed checks",
             name, recv_count - words_before, fail_count - fails_before);
  endtask

  // counts rising edges, both monitors stamp and compare words with the same value
  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= timeout_limit) begin
      $display("simulation timed out after %0d cycles with no end of test", cycle);
      $display("Result: FAILED");
      $finish;
    end
  end

  // every accepted input word becomes one expected output word
  always @(posedge clk) begin
    if (!reset && in_valid && in_ready) begin
      exp_q.push_back(ref_word(in_data, ref_prev, mode));
      in_q.push_back(in_data);
      acc_q.push_back(cycle);
      ref_prev = in_data[lanes-1];
      sent_count++;
    end
  end

  always @(posedge clk) begin
    word_t got;
    word_t exp;
    word_t sent;
    int    accepted_at;
    int    diff;
    if (!reset && out_valid && out_ready) begin
      got = out_data;
      if (exp_q.size() == 0) begin
        fail_count++;
        $display("at %0t an output word arrived while no word was expected", $time);
      end else begin
        exp         = exp_q.pop_front();
        sent        = in_q.pop_front();
        accepted_at = acc_q.pop_front();
        recv_count++;
        assert (got == exp) begin
          pass_count++;
        end else begin
          fail_count++;
          $display("mismatch at %0t: output word got %h expected %h", $time, got, exp);
        end
        if (check_latency) begin
          assert (cycle - accepted_at == 2) begin
            pass_count++;
          end else begin
            fail_count++;
            $display("mismatch at %0t: latency got %0d cycles expected 2",
                     $time, cycle - accepted_at);
          end
        end
        // the rebuilt lane lies within one lsb of the input unless it clipped
        if (mode == mode_sum) begin
          for (int i = 0; i < lanes; i++) begin
            diff = lane_value(got[i]) - lane_value(sent[i]);
            if (lane_value(exp[i]) != sample_max && lane_value(exp[i]) != sample_min) begin
              assert (diff >= -1 && diff <= 1) begin
                pass_count++;
              end else begin
                fail_count++;
                $display("mismatch at %0t: lane %0d rebuilt %0d from input %0d",
                         $time, i, lane_value(got[i]), lane_value(sent[i]));
              end
            end
          end
        end
      end
    end
  end

  initial begin
    int words_before;
    int fails_before;
    clk           = 1'b0;
    reset         = 1'b1;
    mode          = mode_high;
    in_data       = '0;
    in_valid      = 1'b0;
    out_ready     = 1'b0;
    lfsr_state    = 16'd57;
    ref_prev      = '0;
    cycle         = 0;
    sent_count    = 0;
    recv_count    = 0;
    pass_count    = 0;
    fail_count    = 0;
    check_latency = 1'b1;
    repeat (reset_cycles) @(negedge clk);
    reset = 1'b0;

    // lane 0 of the first word is differenced against zero
    words_before = recv_count;
    fails_before = fail_count;
    stream_words(high_words, 1'b0, 1'b0, 1'b0);
    drain_pipeline();
    report_test("test 1 high band at full throughput", words_before, fails_before);

    words_before  = recv_count;
    fails_before  = fail_count;
    mode          = mode_low;
    check_latency = 1'b0;
    stream_words(low_words, 1'b1, 1'b1, 1'b0);
    drain_pipeline();
    report_test("test 2 low band with random valid and ready", words_before, fails_before);

    words_before  = recv_count;
    fails_before  = fail_count;
    mode          = mode_sum;
    check_latency = 1'b1;
    stream_words(sum_words, 1'b0, 1'b0, 1'b0);
    drain_pipeline();
    report_test("test 3 reconstruction from both bands", words_before, fails_before);

    // full scale steps, first as raw differences, then as a clipped sum
    words_before = recv_count;
    fails_before = fail_count;
    mode         = mode_high;
    stream_words(extreme_words, 1'b0, 1'b0, 1'b1);
    drain_pipeline();
    mode = mode_sum;
    stream_words(extreme_words, 1'b0, 1'b0, 1'b1);
    drain_pipeline();
    report_test("test 4 extremes and saturation", words_before, fails_before);

    fails_before = fail_count;
    assert (recv_count == sent_count) begin
      pass_count++;
    end else begin
      fail_count++;
      $display("mismatch at %0t: received %0d words expected %0d", $time, recv_count, sent_count);
    end
    assert (exp_q.size() == 0) begin
      pass_count++;
    end else begin
      fail_count++;
      $display("%0d expected words were never received after draining", exp_q.size());
    end
    $display("test 5 word count finished, %0d sent, %0d received, %0d failed checks",
             sent_count, recv_count, fail_count - fails_before);

    $display("checks passed %0d, checks failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

/* vlog.f */
+incdir+rtl
+incdir+verification
rtl/sample_pkg.sv
rtl/band_ctrl_pkg.sv
rtl/axis_stream_fork.sv
rtl/axis_differentiator.sv
rtl/axis_pair_averager.sv
rtl/axis_band_combiner.sv
rtl/axis_band_split_top.sv
verification/band_split_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# builds the band splitter testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_bin=band_split_sim
log_file=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
  -f vlog.f --top-module band_split_tb -Mdir "$build_dir" -o "$sim_bin"
if [ $? -ne 0 ]; then
  echo "build with Verilator failed"
  exit 1
fi

"./$build_dir/$sim_bin" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "Result: PASSED" "$log_file"; then
  exit 0
fi
echo "pass line not found in $log_file"
exit 1
